// ==== exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int PREG_IDX_W = 6;
    localparam int B_MASK_W   = 4;
    localparam int SHAMT_W    = $clog2(XLEN);

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [PREG_IDX_W-1:0] preg_idx_t;
    // One bit per unresolved branch
    typedef logic [B_MASK_W-1:0]   b_mask_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
    } alu_op_e;

    // Low word, then high word for signed, signed-by-unsigned and unsigned
    typedef enum logic [1:0] {
        MUL, MULH, MULHSU, MULHU
    } mult_op_e;

    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } branch_op_e;

    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        data_t     rs1_value;
        data_t     rs2_value;
        preg_idx_t dest_tag;
        b_mask_t   b_mask;
    } alu_packet_t;

    typedef struct packed {
        logic      valid;
        mult_op_e  op;
        data_t     rs1_value;
        data_t     rs2_value;
        preg_idx_t dest_tag;
        b_mask_t   b_mask;
    } mult_packet_t;

    typedef struct packed {
        logic       valid;
        branch_op_e op;
        data_t      pc;
        data_t      rs1_value;
        data_t      rs2_value;
        data_t      imm;
        logic       pred_taken;
        data_t      pred_target;
        preg_idx_t  dest_tag;
        // One-hot bit this branch owns in the mask
        b_mask_t    b_mask_bit;
    } branch_packet_t;

    typedef struct packed {
        logic      valid;
        preg_idx_t completing_tag;
        data_t     result;
    } cdb_packet_t;

    typedef struct packed {
        logic    valid;
        b_mask_t b_mask_bit;
        logic    mispredict;
        logic    taken;
        data_t   target;
    } branch_reg_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_packet_t alu_packet,
    output exec_pkg::cdb_packet_t alu_result
);

    exec_pkg::data_t a;
    exec_pkg::data_t b;
    exec_pkg::data_t r;
    logic [exec_pkg::SHAMT_W-1:0] shamt;

    assign a     = alu_packet.rs1_value;
    assign b     = alu_packet.rs2_value;
    assign shamt = b[exec_pkg::SHAMT_W-1:0];

    always_comb begin
        case (alu_packet.op)
            exec_pkg::ADD:  r = a + b;
            exec_pkg::SUB:  r = a - b;
            exec_pkg::AND:  r = a & b;
            exec_pkg::OR:   r = a | b;
            exec_pkg::XOR:  r = a ^ b;
            exec_pkg::SLL:  r = a << shamt;
            exec_pkg::SRL:  r = a >> shamt;
            exec_pkg::SRA:  r = exec_pkg::data_t'($signed(a) >>> shamt);
            // Set-less-than gives 0 or 1
            exec_pkg::SLT:  r = exec_pkg::data_t'($signed(a) < $signed(b));
            exec_pkg::SLTU: r = exec_pkg::data_t'(a < b);
            default:        r = '0;
        endcase
    end

    always_comb begin
        alu_result.valid          = alu_packet.valid;
        alu_result.completing_tag = alu_packet.dest_tag;
        alu_result.result         = r;
    end

endmodule

// ==== mult.sv ====
`timescale 1ns/1ps

module mult #(
    parameter int MULT_STAGES = 3
) (
    input  logic                   clock,
    input  logic                   reset,
    input  exec_pkg::mult_packet_t mult_packet_in,
    input  logic                   cdb_gnt,
    input  exec_pkg::b_mask_t      b_mm_resolve,
    input  logic                   b_mm_mispred,
    output logic                   fu_free,
    output logic                   cdb_valid,
    output exec_pkg::cdb_packet_t  mult_result
);

    localparam int XLEN   = exec_pkg::XLEN;
    localparam int PROD_W = 2 * XLEN;
    // Multiplier bits consumed per stage, rounded up
    localparam int CHUNK  = (PROD_W + MULT_STAGES - 1) / MULT_STAGES;
    localparam logic [PROD_W-1:0] CHUNK_MASK = {PROD_W{1'b1}} >> (PROD_W - CHUNK);

    typedef struct packed {
        logic                valid;
        exec_pkg::mult_op_e  op;
        exec_pkg::preg_idx_t dest_tag;
        exec_pkg::b_mask_t   b_mask;
        logic [PROD_W-1:0]   mcand;
        logic [PROD_W-1:0]   mplier;
        logic [PROD_W-1:0]   sum;
    } stage_t;

    stage_t                   entry;
    stage_t [MULT_STAGES-1:0] stage;
    stage_t [MULT_STAGES-1:0] stage_next;
    stage_t                   last;
    logic   [MULT_STAGES-1:0] ready;
    logic                     mcand_signed;
    logic                     mplier_signed;

    // Add one chunk of the partial product
    function automatic stage_t step(stage_t s);
        stage_t r;
        r = s;
        r.sum    = s.sum + s.mcand * (s.mplier & CHUNK_MASK);
        r.mcand  = s.mcand << CHUNK;
        r.mplier = s.mplier >> CHUNK;
        return r;
    endfunction

    // Squash on mispredict, otherwise drop the resolved bits
    function automatic stage_t resolve(stage_t s, exec_pkg::b_mask_t res, logic mispred);
        stage_t r;
        r = s;
        if (|(s.b_mask & res)) begin
            if (mispred) begin
                r.valid = 1'b0;
            end else begin
                r.b_mask = s.b_mask & ~res;
            end
        end
        return r;
    endfunction

    // Operands extended to full product width
    assign mcand_signed  = (mult_packet_in.op == exec_pkg::MULH) ||
                           (mult_packet_in.op == exec_pkg::MULHSU);
    assign mplier_signed = (mult_packet_in.op == exec_pkg::MULH);

    always_comb begin
        entry.valid    = mult_packet_in.valid;
        entry.op       = mult_packet_in.op;
        entry.dest_tag = mult_packet_in.dest_tag;
        entry.b_mask   = mult_packet_in.b_mask;
        entry.mcand    = {{XLEN{mcand_signed & mult_packet_in.rs1_value[XLEN-1]}},
                          mult_packet_in.rs1_value};
        entry.mplier   = {{XLEN{mplier_signed & mult_packet_in.rs2_value[XLEN-1]}},
                          mult_packet_in.rs2_value};
        entry.sum      = '0;
    end

    // A stage moves when it is empty or the one ahead of it moves
    always_comb begin
        ready[MULT_STAGES-1] = !stage[MULT_STAGES-1].valid || cdb_gnt;
        for (int k = MULT_STAGES - 2; k >= 0; k--) begin
            ready[k] = !stage[k].valid || ready[k+1];
        end
        for (int k = 0; k < MULT_STAGES; k++) begin
            if (!ready[k]) begin
                stage_next[k] = stage[k];
            end else if (k == 0) begin
                stage_next[k] = step(entry);
            end else begin
                stage_next[k] = step(stage[k-1]);
            end
            stage_next[k] = resolve(stage_next[k], b_mm_resolve, b_mm_mispred);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < MULT_STAGES; k++) begin
                stage[k].valid <= 1'b0;
            end
        end else begin
            stage <= stage_next;
        end
    end

    assign last      = stage[MULT_STAGES-1];
    assign fu_free   = ready[0];
    assign cdb_valid = last.valid;

    always_comb begin
        mult_result.valid          = last.valid;
        mult_result.completing_tag = last.dest_tag;
        if (last.op == exec_pkg::MUL) begin
            mult_result.result = last.sum[XLEN-1:0];
        end else begin
            mult_result.result = last.sum[PROD_W-1:XLEN];
        end
    end

    // A finished product waits for its grant unless it is squashed
    a_result_held: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid && !cdb_gnt && !(b_mm_mispred && |(last.b_mask & b_mm_resolve))
        |=> cdb_valid
    ) else $error("mult result dropped without grant or squash");

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  exec_pkg::branch_packet_t branch_packet,
    output exec_pkg::cdb_packet_t    branch_result,
    output exec_pkg::branch_reg_t    branch_reg_result
);

    exec_pkg::data_t rs1;
    exec_pkg::data_t rs2;
    exec_pkg::data_t jalr_sum;
    exec_pkg::data_t target;
    logic            taken;
    logic            is_jump;

    assign rs1      = branch_packet.rs1_value;
    assign rs2      = branch_packet.rs2_value;
    assign jalr_sum = rs1 + branch_packet.imm;
    assign is_jump  = (branch_packet.op == exec_pkg::JAL) || (branch_packet.op == exec_pkg::JALR);

    // JALR clears bit 0 of its target
    assign target = (branch_packet.op == exec_pkg::JALR) ? {jalr_sum[exec_pkg::XLEN-1:1], 1'b0}
                                                         : branch_packet.pc + branch_packet.imm;

    always_comb begin
        taken = 1'b0;
        case (branch_packet.op)
            exec_pkg::BEQ:  taken = (rs1 == rs2);
            exec_pkg::BNE:  taken = (rs1 != rs2);
            exec_pkg::BLT:  taken = ($signed(rs1) < $signed(rs2));
            exec_pkg::BGE:  taken = ($signed(rs1) >= $signed(rs2));
            exec_pkg::BLTU: taken = (rs1 < rs2);
            exec_pkg::BGEU: taken = (rs1 >= rs2);
            exec_pkg::JAL,
            exec_pkg::JALR: taken = 1'b1;
        endcase
    end

    always_comb begin
        branch_reg_result = '0;
        if (branch_packet.valid) begin
            branch_reg_result.valid      = 1'b1;
            branch_reg_result.b_mask_bit = branch_packet.b_mask_bit;
            branch_reg_result.taken      = taken;
            branch_reg_result.target     = target;
            // Wrong direction, or taken somewhere else
            branch_reg_result.mispredict = (taken != branch_packet.pred_taken) ||
                                           (taken && target != branch_packet.pred_target);
        end
    end

    // Only jumps write a link register
    always_comb begin
        branch_result.valid          = branch_packet.valid && is_jump;
        branch_result.completing_tag = branch_packet.dest_tag;
        branch_result.result         = branch_packet.pc + exec_pkg::data_t'(4);
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
    parameter  int NUM_ALU      = 2,
    parameter  int NUM_MULT     = 1,
    parameter  int CDB_LANES    = 2,
    parameter  int MULT_STAGES  = 3,
    localparam int NUM_FU_TOTAL = NUM_MULT + NUM_ALU + 1
) (
    input  logic                                      clock,
    input  logic                                      reset,

    input  exec_pkg::alu_packet_t  [NUM_ALU-1:0]      alu_packets_in,
    input  exec_pkg::mult_packet_t [NUM_MULT-1:0]     mult_packets_in,
    input  exec_pkg::branch_packet_t                  branch_packet_in,

    input  logic [NUM_MULT-1:0]                       mult_cdb_gnt,
    input  logic [CDB_LANES-1:0][NUM_FU_TOTAL-1:0]    complete_gnt,
    input  exec_pkg::b_mask_t                         b_mm_resolve,
    input  logic                                      b_mm_mispred,

    output logic [NUM_MULT-1:0]                       mult_free,
    output logic [NUM_MULT-1:0]                       mult_cdb_valid,

    output exec_pkg::cdb_packet_t  [CDB_LANES-1:0]    cdb_completing,
    output exec_pkg::cdb_packet_t  [CDB_LANES-1:0]    cdb_reg,
    output exec_pkg::branch_reg_t                     branch_reg
);

    exec_pkg::alu_packet_t    [NUM_ALU-1:0]      alu_issued;
    exec_pkg::alu_packet_t    [NUM_ALU-1:0]      alu_active;
    exec_pkg::branch_packet_t                    branch_issued;
    exec_pkg::branch_packet_t                    branch_active;

    exec_pkg::cdb_packet_t    [NUM_ALU-1:0]      alu_result;
    exec_pkg::cdb_packet_t    [NUM_MULT-1:0]     mult_result;
    exec_pkg::cdb_packet_t                       branch_result;
    exec_pkg::cdb_packet_t    [NUM_FU_TOTAL-1:0] fu_result;
    exec_pkg::branch_reg_t                       next_branch_reg;

    logic [NUM_FU_TOTAL-1:0][CDB_LANES-1:0]      gnt_by_fu;

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_issued    <= '0;
            branch_issued <= '0;
        end else begin
            alu_issued    <= alu_packets_in;
            branch_issued <= branch_packet_in;
        end
    end

    // Drop registered packets hit by a mispredict this cycle
    always_comb begin
        for (int i = 0; i < NUM_ALU; i++) begin
            alu_active[i] = alu_issued[i];
            if (b_mm_mispred && |(alu_issued[i].b_mask & b_mm_resolve)) begin
                alu_active[i].valid = 1'b0;
            end
        end
        branch_active = branch_issued;
        if (b_mm_mispred && |(branch_issued.b_mask_bit & b_mm_resolve)) begin
            branch_active.valid = 1'b0;
        end
    end

    for (genvar i = 0; i < NUM_ALU; i++) begin : g_alu
        alu alu_fu (
            .alu_packet (alu_active[i]),
            .alu_result (alu_result[i])
        );
    end

    for (genvar i = 0; i < NUM_MULT; i++) begin : g_mult
        mult #(
            .MULT_STAGES (MULT_STAGES)
        ) mult_fu (
            .clock          (clock),
            .reset          (reset),
            .mult_packet_in (mult_packets_in[i]),
            .cdb_gnt        (mult_cdb_gnt[i]),
            .b_mm_resolve   (b_mm_resolve),
            .b_mm_mispred   (b_mm_mispred),
            .fu_free        (mult_free[i]),
            .cdb_valid      (mult_cdb_valid[i]),
            .mult_result    (mult_result[i])
        );
    end

    branch_unit branch_fu (
        .branch_packet     (branch_active),
        .branch_result     (branch_result),
        .branch_reg_result (next_branch_reg)
    );

    // FU order on the grant bus: mults, ALUs, branch
    assign fu_result = {branch_result, alu_result, mult_result};

    always_comb begin
        cdb_completing = '0;
        for (int l = 0; l < CDB_LANES; l++) begin
            for (int j = 0; j < NUM_FU_TOTAL; j++) begin
                if (complete_gnt[l][j]) begin
                    cdb_completing[l] = fu_result[j];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_reg    <= '0;
            branch_reg <= '0;
        end else begin
            cdb_reg    <= cdb_completing;
            branch_reg <= next_branch_reg;
        end
    end

    always_comb begin
        for (int l = 0; l < CDB_LANES; l++) begin
            for (int j = 0; j < NUM_FU_TOTAL; j++) begin
                gnt_by_fu[j][l] = complete_gnt[l][j];
            end
        end
    end

    for (genvar l = 0; l < CDB_LANES; l++) begin : g_lane_chk
        a_lane_onehot: assert property (
            @(posedge clock) disable iff (reset) $onehot0(complete_gnt[l])
        ) else $error("lane %0d granted to several FUs", l);
    end

    for (genvar j = 0; j < NUM_FU_TOTAL; j++) begin : g_fu_chk
        a_fu_single_lane: assert property (
            @(posedge clock) disable iff (reset) $onehot0(gnt_by_fu[j])
        ) else $error("FU %0d granted on several lanes", j);
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Release reset a little after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #10;
        reset = 1'b0;
    end

endmodule

// ==== execute_stage_tb.sv ====
`timescale 1ns/1ps

module execute_stage_tb;

    localparam int NUM_ALU      = 2;
    localparam int NUM_MULT     = 1;
    localparam int CDB_LANES    = 2;
    localparam int MULT_STAGES  = 3;
    localparam int NUM_FU_TOTAL = NUM_MULT + NUM_ALU + 1;

    // Grant bus order is mults, then ALUs, then branch
    localparam int MULT_IDX   = 0;
    localparam int ALU_IDX    = NUM_MULT;
    localparam int BRANCH_IDX = NUM_MULT + NUM_ALU;

    // Several times the length of all tests together
    localparam int MAX_CYCLES = 400;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clock;
    logic reset;

    exec_pkg::alu_packet_t  [NUM_ALU-1:0]           alu_packets_in;
    exec_pkg::mult_packet_t [NUM_MULT-1:0]          mult_packets_in;
    exec_pkg::branch_packet_t                       branch_packet_in;
    logic [NUM_MULT-1:0]                            mult_cdb_gnt;
    logic [CDB_LANES-1:0][NUM_FU_TOTAL-1:0]         complete_gnt;
    exec_pkg::b_mask_t                              b_mm_resolve;
    logic                                           b_mm_mispred;
    logic [NUM_MULT-1:0]                            mult_free;
    logic [NUM_MULT-1:0]                            mult_cdb_valid;
    exec_pkg::cdb_packet_t  [CDB_LANES-1:0]         cdb_completing;
    exec_pkg::cdb_packet_t  [CDB_LANES-1:0]         cdb_reg;
    exec_pkg::branch_reg_t                          branch_reg;

    logic [31:0] lfsr = 32'h9f97;
    int          checks = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          cycles = 0;
    string       test_name = "";

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (3)
    ) clock_gen (
        .clock (clock),
        .reset (reset)
    );

    execute_stage #(
        .NUM_ALU     (NUM_ALU),
        .NUM_MULT    (NUM_MULT),
        .CDB_LANES   (CDB_LANES),
        .MULT_STAGES (MULT_STAGES)
    ) UUT (
        .clock            (clock),
        .reset            (reset),
        .alu_packets_in   (alu_packets_in),
        .mult_packets_in  (mult_packets_in),
        .branch_packet_in (branch_packet_in),
        .mult_cdb_gnt     (mult_cdb_gnt),
        .complete_gnt     (complete_gnt),
        .b_mm_resolve     (b_mm_resolve),
        .b_mm_mispred     (b_mm_mispred),
        .mult_free        (mult_free),
        .mult_cdb_valid   (mult_cdb_valid),
        .cdb_completing   (cdb_completing),
        .cdb_reg          (cdb_reg),
        .branch_reg       (branch_reg)
    );

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [NUM_FU_TOTAL-1:0] fu_grant(int idx);
        logic [NUM_FU_TOTAL-1:0] v;
        v      = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    function automatic exec_pkg::cdb_packet_t make_cdb(exec_pkg::preg_idx_t tag,
                                                       exec_pkg::data_t value);
        exec_pkg::cdb_packet_t p;
        p.valid          = 1'b1;
        p.completing_tag = tag;
        p.result         = value;
        return p;
    endfunction

    function automatic exec_pkg::data_t alu_model(exec_pkg::alu_op_e op,
                                                  exec_pkg::data_t a, exec_pkg::data_t b);
        exec_pkg::data_t r;
        logic [4:0]      sh;
        sh = b[4:0];
        case (op)
            exec_pkg::ADD:  r = a + b;
            exec_pkg::SUB:  r = a - b;
            exec_pkg::AND:  r = a & b;
            exec_pkg::OR:   r = a | b;
            exec_pkg::XOR:  r = a ^ b;
            exec_pkg::SLL:  r = a << sh;
            exec_pkg::SRL:  r = a >> sh;
            exec_pkg::SRA:  r = $signed(a) >>> sh;
            exec_pkg::SLT:  r = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::SLTU: r = {31'b0, a < b};
            default:        r = '0;
        endcase
        return r;
    endfunction

    // Operands extended by signedness into a full 64-bit product
    function automatic exec_pkg::data_t mult_model(exec_pkg::mult_op_e op,
                                                   exec_pkg::data_t a, exec_pkg::data_t b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (op)
            exec_pkg::MULH:   p = sa * sb;
            exec_pkg::MULHSU: p = sa * ub;
            default:          p = ua * ub;
        endcase
        return (op == exec_pkg::MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_taken(exec_pkg::branch_op_e op,
                                          exec_pkg::data_t a, exec_pkg::data_t b);
        case (op)
            exec_pkg::BEQ:  return a == b;
            exec_pkg::BNE:  return a != b;
            exec_pkg::BLT:  return $signed(a) < $signed(b);
            exec_pkg::BGE:  return $signed(a) >= $signed(b);
            exec_pkg::BLTU: return a < b;
            exec_pkg::BGEU: return a >= b;
            default:        return 1'b1;
        endcase
    endfunction

    function automatic exec_pkg::data_t branch_target(exec_pkg::branch_packet_t p);
        if (p.op == exec_pkg::JALR) begin
            return (p.rs1_value + p.imm) & ~32'd1;
        end
        return p.pc + p.imm;
    endfunction

    function automatic exec_pkg::branch_reg_t branch_expect(exec_pkg::branch_packet_t p);
        exec_pkg::branch_reg_t r;
        r            = '0;
        r.valid      = 1'b1;
        r.b_mask_bit = p.b_mask_bit;
        r.taken      = branch_taken(p.op, p.rs1_value, p.rs2_value);
        r.target     = branch_target(p);
        r.mispredict = (r.taken != p.pred_taken) || (r.taken && r.target != p.pred_target);
        return r;
    endfunction

    task automatic compare(input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic clear_inputs();
        alu_packets_in   = '0;
        mult_packets_in  = '0;
        branch_packet_in = '0;
        mult_cdb_gnt     = '0;
        complete_gnt     = '0;
        b_mm_resolve     = '0;
        b_mm_mispred     = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic report_test();
        $display("%s finished, %0d mismatches", test_name, errors - errors_at_start);
    endtask

    task automatic reset_test();
        begin_test("reset");
        for (int l = 0; l < CDB_LANES; l++) begin
            compare(64'(0), 64'(cdb_reg[l]));
        end
        compare(64'(0), 64'(branch_reg));
        compare(64'(0), 64'(mult_cdb_valid));
        compare(64'(1'b1), 64'(mult_free[0]));
        report_test();
    endtask

    task automatic alu_ops_test();
        exec_pkg::alu_packet_t pkt;
        exec_pkg::cdb_packet_t expected;
        begin_test("alu_ops");
        for (int op = 0; op < 10; op++) begin
            pkt           = '0;
            pkt.valid     = 1'b1;
            pkt.op        = exec_pkg::alu_op_e'(op[3:0]);
            pkt.rs1_value = rand_bits(32);
            pkt.rs2_value = rand_bits(32);
            pkt.dest_tag  = exec_pkg::preg_idx_t'(op + 1);
            expected = make_cdb(pkt.dest_tag, alu_model(pkt.op, pkt.rs1_value, pkt.rs2_value));
            alu_packets_in[0] = pkt;
            next_cycle();
            alu_packets_in[0] = '0;
            complete_gnt[0]   = fu_grant(ALU_IDX);
            next_cycle();
            complete_gnt[0] = '0;
            compare(64'(expected), 64'(cdb_reg[0]));
        end
        report_test();
    endtask

    task automatic two_lane_test();
        exec_pkg::alu_packet_t    alu_pkt;
        exec_pkg::branch_packet_t br_pkt;
        exec_pkg::cdb_packet_t    alu_exp;
        exec_pkg::cdb_packet_t    link_exp;
        exec_pkg::branch_reg_t    br_exp;
        begin_test("two_lanes");
        alu_pkt           = '0;
        alu_pkt.valid     = 1'b1;
        alu_pkt.op        = exec_pkg::ADD;
        alu_pkt.rs1_value = rand_bits(32);
        alu_pkt.rs2_value = rand_bits(32);
        alu_pkt.dest_tag  = 6'd11;
        br_pkt            = '0;
        br_pkt.valid      = 1'b1;
        br_pkt.op         = exec_pkg::JAL;
        br_pkt.pc         = rand_bits(32) & 32'hFFFF_FFFC;
        br_pkt.imm        = 32'h0000_0100;
        br_pkt.pred_taken = 1'b1;
        // Predicted target is off by one instruction
        br_pkt.pred_target = br_pkt.pc + 32'h0000_0104;
        br_pkt.dest_tag    = 6'd12;
        br_pkt.b_mask_bit  = 4'b0100;
        alu_exp  = make_cdb(alu_pkt.dest_tag,
                            alu_model(alu_pkt.op, alu_pkt.rs1_value, alu_pkt.rs2_value));
        link_exp = make_cdb(br_pkt.dest_tag, br_pkt.pc + 32'd4);
        br_exp   = branch_expect(br_pkt);
        alu_packets_in[1] = alu_pkt;
        branch_packet_in  = br_pkt;
        next_cycle();
        alu_packets_in[1] = '0;
        branch_packet_in  = '0;
        complete_gnt[0]   = fu_grant(ALU_IDX + 1);
        complete_gnt[1]   = fu_grant(BRANCH_IDX);
        next_cycle();
        complete_gnt = '0;
        compare(64'(alu_exp), 64'(cdb_reg[0]));
        compare(64'(link_exp), 64'(cdb_reg[1]));
        compare(64'(br_exp), 64'(branch_reg));
        report_test();
    endtask

    task automatic branch_resolve_test();
        exec_pkg::branch_packet_t pkt;
        exec_pkg::branch_reg_t    expected;
        logic [31:0]              offset;
        logic                     taken;
        logic                     is_jump;
        begin_test("branch_resolve");
        for (int op = 0; op < 8; op++) begin
            for (int right = 1; right >= 0; right--) begin
                pkt           = '0;
                pkt.valid     = 1'b1;
                pkt.op        = exec_pkg::branch_op_e'(op[2:0]);
                pkt.pc        = rand_bits(32) & 32'hFFFF_FFFC;
                offset        = rand_bits(12);
                pkt.imm       = {{20{offset[11]}}, offset[11:1], 1'b0};
                pkt.rs1_value = rand_bits(32);
                pkt.rs2_value = rand_bits(32);
                // Equal operands now and then
                if (rand_bits(1) != 0) begin
                    pkt.rs2_value = pkt.rs1_value;
                end
                taken           = branch_taken(pkt.op, pkt.rs1_value, pkt.rs2_value);
                pkt.pred_taken  = (right == 1) ? taken : !taken;
                pkt.pred_target = branch_target(pkt);
                pkt.dest_tag    = exec_pkg::preg_idx_t'(op + 40);
                pkt.b_mask_bit  = exec_pkg::b_mask_t'(1) << op[1:0];
                expected = branch_expect(pkt);
                is_jump  = (pkt.op == exec_pkg::JAL) || (pkt.op == exec_pkg::JALR);
                branch_packet_in = pkt;
                next_cycle();
                branch_packet_in = '0;
                complete_gnt[0]  = fu_grant(BRANCH_IDX);
                next_cycle();
                complete_gnt[0] = '0;
                compare(64'(expected), 64'(branch_reg));
                compare(64'(is_jump), 64'(cdb_reg[0].valid));
                if (is_jump) begin
                    compare(64'(pkt.pc + 32'd4), 64'(cdb_reg[0].result));
                end
            end
        end
        report_test();
    endtask

    task automatic mult_backpressure_test();
        exec_pkg::mult_packet_t pkt [4];
        exec_pkg::cdb_packet_t  expected [4];
        int                     issued;
        int                     received;
        logic                   granting;
        logic                   granted_prev;
        begin_test("mult_backpressure");
        for (int i = 0; i < 4; i++) begin
            pkt[i]           = '0;
            pkt[i].valid     = 1'b1;
            pkt[i].op        = exec_pkg::mult_op_e'(i[1:0]);
            pkt[i].rs1_value = rand_bits(32);
            pkt[i].rs2_value = rand_bits(32);
            pkt[i].dest_tag  = exec_pkg::preg_idx_t'(20 + i);
            expected[i] = make_cdb(pkt[i].dest_tag,
                                   mult_model(pkt[i].op, pkt[i].rs1_value, pkt[i].rs2_value));
        end
        issued       = 0;
        received     = 0;
        granting     = 1'b0;
        granted_prev = 1'b0;
        while (received < 4) begin
            if (granted_prev) begin
                compare(64'(expected[received-1]), 64'(cdb_reg[0]));
            end
            granted_prev = 1'b0;
            mult_cdb_gnt[0] = granting && mult_cdb_valid[0];
            complete_gnt[0] = mult_cdb_gnt[0] ? fu_grant(MULT_IDX) : '0;
            if (issued < 4) begin
                mult_packets_in[0] = pkt[issued];
            end else begin
                mult_packets_in[0] = '0;
            end
            #1;
            if (mult_cdb_gnt[0]) begin
                compare(64'(expected[received]), 64'(cdb_completing[0]));
                received++;
                granted_prev = 1'b1;
            end
            if (issued < 4 && mult_free[0]) begin
                issued++;
            end
            // Stall comes once every stage holds a product, then grants start
            if (!mult_free[0] && !granting) begin
                compare(64'(MULT_STAGES), 64'(issued));
                granting = 1'b1;
            end
            next_cycle();
        end
        clear_inputs();
        compare(64'(expected[3]), 64'(cdb_reg[0]));
        compare(64'(0), 64'(mult_cdb_valid[0]));
        report_test();
    endtask

    task automatic mult_squash_test();
        exec_pkg::mult_packet_t first;
        exec_pkg::mult_packet_t second;
        exec_pkg::cdb_packet_t  expected;
        begin_test("mult_squash");
        first            = '0;
        first.valid      = 1'b1;
        first.op         = exec_pkg::MUL;
        first.rs1_value  = rand_bits(32);
        first.rs2_value  = rand_bits(32);
        first.dest_tag   = 6'd30;
        first.b_mask     = 4'b0001;
        second           = '0;
        second.valid     = 1'b1;
        second.op        = exec_pkg::MULHU;
        second.rs1_value = rand_bits(32);
        second.rs2_value = rand_bits(32);
        second.dest_tag  = 6'd31;
        second.b_mask    = 4'b0010;
        expected = make_cdb(second.dest_tag,
                            mult_model(second.op, second.rs1_value, second.rs2_value));
        mult_packets_in[0] = first;
        next_cycle();
        mult_packets_in[0] = second;
        next_cycle();
        mult_packets_in[0] = '0;
        b_mm_resolve       = 4'b0001;
        b_mm_mispred       = 1'b1;
        next_cycle();
        b_mm_resolve = 4'b0010;
        b_mm_mispred = 1'b0;
        next_cycle();
        // Bit already cleared, so this must not hit the second product
        b_mm_resolve = 4'b0010;
        b_mm_mispred = 1'b1;
        next_cycle();
        b_mm_resolve = '0;
        b_mm_mispred = 1'b0;
        while (!mult_cdb_valid[0]) begin
            next_cycle();
        end
        mult_cdb_gnt[0] = 1'b1;
        complete_gnt[0] = fu_grant(MULT_IDX);
        #1;
        compare(64'(expected), 64'(cdb_completing[0]));
        next_cycle();
        clear_inputs();
        compare(64'(expected), 64'(cdb_reg[0]));
        compare(64'(0), 64'(mult_cdb_valid[0]));
        compare(64'(1'b1), 64'(mult_free[0]));
        report_test();
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clear_inputs();
        @(negedge reset);
        reset_test();
        alu_ops_test();
        two_lane_test();
        branch_resolve_test();
        mult_backpressure_test();
        mult_squash_test();
        $display("Summary: %0d checks run, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
exec_pkg.sv
alu.sv
mult.sv
branch_unit.sv
execute_stage.sv
tb_clock_gen.sv
execute_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= execute_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
